/* verilog/osd_trace_pkg.sv */
// Shared types and constants of the debug event trace port
package osd_trace_pkg;

   // One flit payload on the debug interconnect
   typedef logic [15:0] dii_word;

   // DI module address, used for SRC and DEST
   typedef logic [15:0] dii_addr;

   // Dropped event count, saturates at all ones
   typedef logic [15:0] ovf_count;

   // FLAGS bits 15:14
   typedef logic [1:0] pkt_type;

   // FLAGS bits 13:10
   typedef logic [3:0] pkt_type_sub;

   // Packet type of all trace packets
   localparam pkt_type TYPE_EVENT = 2'b10;

   // Sub-types: first packet, continuation, overflow report
   localparam pkt_type_sub TYPE_SUB_FIRST = 4'd0;
   localparam pkt_type_sub TYPE_SUB_CONT = 4'd1;
   localparam pkt_type_sub TYPE_SUB_OVERFLOW = 4'd5;

   // DEST, SRC and FLAGS
   localparam int HDR_FLITS = 3;

endpackage

/* verilog/osd_event_capture.sv */
`timescale 1ns/1ns

module osd_event_capture
   import osd_trace_pkg::*;
#(
   parameter int DATA_WIDTH = 16
) (
   input                         clk,
   input                         rst,

   // Single-cycle event strobe from the traced block
   input                         trace_valid,
   input        [DATA_WIDTH-1:0] trace_data,

   // Pending item towards the packetizer
   output logic                  event_available,
   output logic                  overflow,
   output logic [DATA_WIDTH-1:0] event_data,
   input                         event_consumed
);

   typedef enum logic [1:0] {
      EMPTY,
      EVENT_PENDING,
      OVERFLOW_PENDING
   } capture_state_t;

   capture_state_t state;

   // Lost events since the last report
   ovf_count drop_cnt;
   // Counter value including a drop in this cycle
   ovf_count drop_cnt_inc;

   logic accept;
   logic drop;
   logic report;

   // Only an empty stage takes a new event
   assign accept = trace_valid && (state == EMPTY);

   // Anything else is lost, even in the cycle of event_consumed
   assign drop = trace_valid && (state != EMPTY);

   always_comb begin
      drop_cnt_inc = drop_cnt;
      // Saturate, never wrap back to zero
      if (drop && (drop_cnt != '1)) begin
         drop_cnt_inc = drop_cnt + 1'b1;
      end
   end

   // Consumed item with losses pending turns into an overflow report
   assign report = event_consumed && (drop_cnt_inc != '0);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= EMPTY;
         drop_cnt <= '0;
      end else begin
         case (state)
            EMPTY: begin
               if (accept) begin
                  state <= EVENT_PENDING;
               end
            end
            EVENT_PENDING, OVERFLOW_PENDING: begin
               if (event_consumed) begin
                  // Counter is snapshotted into the report, start over
                  drop_cnt <= '0;
                  if (report) begin
                     state <= OVERFLOW_PENDING;
                  end else begin
                     state <= EMPTY;
                  end
               end else begin
                  drop_cnt <= drop_cnt_inc;
               end
            end
            default: begin
               state <= EMPTY;
            end
         endcase
      end
   end

   // Event payload, or the lost count zero-extended
   always_ff @(posedge clk) begin
      if (accept) begin
         event_data <= trace_data;
      end else if (report) begin
         event_data <= DATA_WIDTH'(drop_cnt_inc);
      end
   end

   assign event_available = (state != EMPTY);
   assign overflow = (state == OVERFLOW_PENDING);

endmodule

/* verilog/osd_event_packetization.sv */
`timescale 1ns/1ns

module osd_event_packetization
   import osd_trace_pkg::*;
#(
   // Packet length limit in flits, header included
   parameter int MAX_PKT_LEN = 12,
   // Upper bound of data_num_words
   parameter int MAX_DATA_NUM_WORDS = 1,

   localparam int IDX_W = (MAX_DATA_NUM_WORDS > 1) ? $clog2(MAX_DATA_NUM_WORDS) : 1,
   localparam int CNT_W = $clog2(MAX_DATA_NUM_WORDS + 1)
) (
   input                    clk,
   input                    rst,

   // Flit output with valid/ready handshake
   output dii_word          debug_out_data,
   output logic             debug_out_last,
   output logic             debug_out_valid,
   input                    debug_out_ready,

   // SRC address of this module
   input  dii_addr          id,
   // DEST address of the event receiver
   input  dii_addr          dest,

   // Current item is an overflow report
   input                    overflow,
   input                    event_available,
   output logic             event_consumed,

   // Indexed word read, answered in the same cycle
   input        [CNT_W-1:0] data_num_words,
   output logic [IDX_W-1:0] data_req_idx,
   input  dii_word          data
);

   localparam int FC_W = $clog2(MAX_PKT_LEN + 1);

   // State names the flit currently on the output
   typedef enum logic [2:0] {
      IDLE,
      HDR_DEST,
      HDR_SRC,
      HDR_FLAGS,
      PAYLOAD
   } pkt_state_t;

   pkt_state_t state;
   pkt_state_t state_next;

   // Flits of the current packet, the one on the output included
   logic [FC_W-1:0] flit_cnt;
   logic [FC_W-1:0] flit_cnt_next;

   // Next word to load
   logic [IDX_W-1:0] word_idx;
   logic [IDX_W-1:0] word_idx_next;

   // Continuation packet of the same event
   logic cont_pkt;
   logic cont_pkt_next;

   // Packet on the output ends the whole item
   logic final_pkt;
   logic final_pkt_next;

   logic valid_next;
   logic last_next;
   dii_word data_next;

   logic xfer;
   logic [CNT_W-1:0] last_word_idx;
   logic word_last;
   pkt_type_sub sub_type;
   dii_word flags_word;

   assign xfer = debug_out_valid && debug_out_ready;

   // An overflow report always has exactly one word
   assign last_word_idx = overflow ? '0 : data_num_words - 1'b1;
   assign word_last = (CNT_W'(word_idx) == last_word_idx);

   always_comb begin
      if (overflow) begin
         sub_type = TYPE_SUB_OVERFLOW;
      end else if (cont_pkt) begin
         sub_type = TYPE_SUB_CONT;
      end else begin
         sub_type = TYPE_SUB_FIRST;
      end
   end

   // Lower 10 bits of FLAGS are reserved
   assign flags_word = {TYPE_EVENT, sub_type, 10'b0};

   assign data_req_idx = word_idx;

   // Last flit of the last packet
   assign event_consumed = xfer && (state == PAYLOAD) && debug_out_last && final_pkt;

   always_comb begin
      state_next = state;
      valid_next = debug_out_valid;
      last_next = debug_out_last;
      data_next = debug_out_data;
      flit_cnt_next = flit_cnt;
      word_idx_next = word_idx;
      cont_pkt_next = cont_pkt;
      final_pkt_next = final_pkt;

      case (state)
         IDLE: begin
            if (event_available) begin
               state_next = HDR_DEST;
               valid_next = 1'b1;
               last_next = 1'b0;
               data_next = dest;
               flit_cnt_next = FC_W'(1);
               word_idx_next = '0;
               cont_pkt_next = 1'b0;
               final_pkt_next = 1'b0;
            end
         end
         HDR_DEST: begin
            if (xfer) begin
               state_next = HDR_SRC;
               data_next = id;
               flit_cnt_next = flit_cnt + 1'b1;
            end
         end
         HDR_SRC: begin
            if (xfer) begin
               state_next = HDR_FLAGS;
               data_next = flags_word;
               flit_cnt_next = FC_W'(HDR_FLITS);
            end
         end
         HDR_FLAGS, PAYLOAD: begin
            if (xfer) begin
               if ((state == PAYLOAD) && debug_out_last) begin
                  if (final_pkt) begin
                     // Done, idle for at least one cycle
                     state_next = IDLE;
                     valid_next = 1'b0;
                     last_next = 1'b0;
                  end else begin
                     // Words remain, continuation follows without a gap
                     state_next = HDR_DEST;
                     data_next = dest;
                     last_next = 1'b0;
                     flit_cnt_next = FC_W'(1);
                     cont_pkt_next = 1'b1;
                  end
               end else begin
                  // Load the next payload word
                  state_next = PAYLOAD;
                  data_next = data;
                  word_idx_next = word_idx + 1'b1;
                  flit_cnt_next = flit_cnt + 1'b1;
                  last_next = word_last || (flit_cnt == FC_W'(MAX_PKT_LEN - 1));
                  final_pkt_next = word_last;
               end
            end
         end
         default: begin
            state_next = IDLE;
            valid_next = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         debug_out_valid <= 1'b0;
         debug_out_last <= 1'b0;
         flit_cnt <= '0;
         word_idx <= '0;
         cont_pkt <= 1'b0;
         final_pkt <= 1'b0;
      end else begin
         state <= state_next;
         debug_out_valid <= valid_next;
         debug_out_last <= last_next;
         flit_cnt <= flit_cnt_next;
         word_idx <= word_idx_next;
         cont_pkt <= cont_pkt_next;
         final_pkt <= final_pkt_next;
      end
   end

   // Flit payload, held while stalled
   always_ff @(posedge clk) begin
      debug_out_data <= data_next;
   end

endmodule

/* verilog/osd_event_packetization_fixedwidth.sv */
`timescale 1ns/1ns

module osd_event_packetization_fixedwidth
   import osd_trace_pkg::*;
#(
   parameter int MAX_PKT_LEN = 12,
   parameter int DATA_WIDTH = 16,

   localparam int DATA_NUM_WORDS = (DATA_WIDTH + 15) / 16,
   localparam int IDX_W = (DATA_NUM_WORDS > 1) ? $clog2(DATA_NUM_WORDS) : 1,
   localparam int CNT_W = $clog2(DATA_NUM_WORDS + 1)
) (
   input                   clk,
   input                   rst,

   output dii_word         debug_out_data,
   output logic            debug_out_last,
   output logic            debug_out_valid,
   input                   debug_out_ready,

   input  dii_addr         id,
   input  dii_addr         dest,

   input                   overflow,
   input                   event_available,
   output logic            event_consumed,

   // Whole event, held until event_consumed
   input  [DATA_WIDTH-1:0] data
);

   // Event rounded up to whole words
   localparam int PAD_W = DATA_NUM_WORDS * 16;

   logic [IDX_W-1:0] data_req_idx;
   dii_word data_word;
   logic [PAD_W-1:0] data_padded;

   // Zero fill above the top event bit
   assign data_padded = PAD_W'(data);

   // Word k is bits 16k+15 down to 16k
   always_comb begin
      if (data_req_idx < DATA_NUM_WORDS) begin
         data_word = data_padded[data_req_idx * 16 +: 16];
      end else begin
         data_word = '0;
      end
   end

   osd_event_packetization #(
      .MAX_PKT_LEN        (MAX_PKT_LEN),
      .MAX_DATA_NUM_WORDS (DATA_NUM_WORDS)
   ) i_osd_event_packetization (
      .clk             (clk),
      .rst             (rst),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready),
      .id              (id),
      .dest            (dest),
      .overflow        (overflow),
      .event_available (event_available),
      .event_consumed  (event_consumed),
      // Word count is fixed by DATA_WIDTH
      .data_num_words  (CNT_W'(DATA_NUM_WORDS)),
      .data_req_idx    (data_req_idx),
      .data            (data_word)
   );

endmodule

/* verilog/osd_event_trace_top.sv */
`timescale 1ns/1ns

module osd_event_trace_top
   import osd_trace_pkg::*;
#(
   // Flits per packet, at least 4
   parameter int MAX_PKT_LEN = 12,
   // Event width, at least 16
   parameter int DATA_WIDTH = 16
) (
   input                   clk,
   input                   rst,

   // Own DI address and the event destination
   input  dii_addr         id,
   input  dii_addr         dest,

   // Trace strobe, no back-pressure
   input                   trace_valid,
   input  [DATA_WIDTH-1:0] trace_data,

   // Towards the debug interconnect
   output dii_word         debug_out_data,
   output logic            debug_out_last,
   output logic            debug_out_valid,
   input                   debug_out_ready
);

   // Capture to packetizer link
   logic event_available;
   logic overflow;
   logic [DATA_WIDTH-1:0] event_data;
   logic event_consumed;

   // One pending event plus the lost-event counter
   osd_event_capture #(
      .DATA_WIDTH (DATA_WIDTH)
   ) i_osd_event_capture (
      .clk             (clk),
      .rst             (rst),
      .trace_valid     (trace_valid),
      .trace_data      (trace_data),
      .event_available (event_available),
      .overflow        (overflow),
      .event_data      (event_data),
      .event_consumed  (event_consumed)
   );

   // Word split and packet framing
   osd_event_packetization_fixedwidth #(
      .MAX_PKT_LEN (MAX_PKT_LEN),
      .DATA_WIDTH  (DATA_WIDTH)
   ) i_osd_event_packetization_fixedwidth (
      .clk             (clk),
      .rst             (rst),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready),
      .id              (id),
      .dest            (dest),
      .overflow        (overflow),
      .event_available (event_available),
      .event_consumed  (event_consumed),
      .data            (event_data)
   );

endmodule

/* verification/osd_event_trace_tb.sv */
`timescale 1ns/1ns

module osd_event_trace_tb
   import osd_trace_pkg::*;
;

   localparam int DATA_WIDTH = 72;
   localparam int MAX_PKT_LEN = 6;
   // Five words with 8 event bits in the top one
   localparam int NUM_WORDS = 5;
   localparam int PAYLOAD_PER_PKT = MAX_PKT_LEN - HDR_FLITS;
   // Packets of 3 + 3 and 3 + 2 flits
   localparam int FLITS_PER_EVENT = 11;
   localparam int BP_EVENTS = 4;
   localparam int CLK_PERIOD = 10;
   // Summed test length in cycles with random ready at a third of full rate
   localparam int TEST_CYCLES = 16 + 10 + (FLITS_PER_EVENT + 10)
      + BP_EVENTS * (3 * FLITS_PER_EVENT + 10) + 2 * (FLITS_PER_EVENT + 30);
   localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD * 4;

   // Ready modes of the receiver
   localparam int READY_LOW = 0;
   localparam int READY_HIGH = 1;
   localparam int READY_RANDOM = 2;

   logic clk;
   logic rst;
   dii_addr id;
   dii_addr dest;
   logic trace_valid;
   logic [DATA_WIDTH-1:0] trace_data;
   dii_word debug_out_data;
   logic debug_out_last;
   logic debug_out_valid;
   logic debug_out_ready;

   integer seed;
   int ready_mode;
   logic [31:0] ready_rnd;

   // Expected flits in order
   dii_word exp_data[$];
   logic exp_last[$];

   osd_event_trace_top #(
      .MAX_PKT_LEN (MAX_PKT_LEN),
      .DATA_WIDTH  (DATA_WIDTH)
   ) i_osd_event_trace_top (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .dest            (dest),
      .trace_valid     (trace_valid),
      .trace_data      (trace_data),
      .debug_out_data  (debug_out_data),
      .debug_out_last  (debug_out_last),
      .debug_out_valid (debug_out_valid),
      .debug_out_ready (debug_out_ready)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Receiver ready changes on the falling edge only
   always @(negedge clk) begin
      case (ready_mode)
         READY_LOW: debug_out_ready <= 1'b0;
         READY_HIGH: debug_out_ready <= 1'b1;
         default: begin
            ready_rnd = $random(seed);
            debug_out_ready <= ready_rnd[0];
         end
      endcase
   end

   task automatic abort_run();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input dii_word got, input dii_word exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_last(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   // DEST and SRC followed by FLAGS with type 2 in bits 15:14 and the sub-type below
   task automatic queue_header(input pkt_type_sub sub);
      exp_data.push_back(dest);
      exp_last.push_back(1'b0);
      exp_data.push_back(id);
      exp_last.push_back(1'b0);
      exp_data.push_back({2'b10, sub, 10'h000});
      exp_last.push_back(1'b0);
   endtask

   // Packet rule applied to one event with the low word first
   task automatic queue_event(input logic [DATA_WIDTH-1:0] ev);
      logic [NUM_WORDS*16-1:0] padded;
      int idx;
      int n;
      padded = '0;
      padded[DATA_WIDTH-1:0] = ev;
      idx = 0;
      while (idx < NUM_WORDS) begin
         if (idx == 0) begin
            queue_header(TYPE_SUB_FIRST);
         end else begin
            queue_header(TYPE_SUB_CONT);
         end
         n = 0;
         while ((n < PAYLOAD_PER_PKT) && (idx < NUM_WORDS)) begin
            exp_data.push_back(padded[idx*16 +: 16]);
            exp_last.push_back((n == PAYLOAD_PER_PKT - 1) || (idx == NUM_WORDS - 1));
            idx++;
            n++;
         end
      end
   endtask

   // Overflow report is one packet with the count as its only word
   task automatic queue_overflow(input ovf_count count);
      queue_header(TYPE_SUB_OVERFLOW);
      exp_data.push_back(count);
      exp_last.push_back(1'b1);
   endtask

   // One-cycle strobe
   task automatic send_event(input logic [DATA_WIDTH-1:0] ev);
      @(negedge clk);
      trace_valid = 1'b1;
      trace_data = ev;
      @(negedge clk);
      trace_valid = 1'b0;
   endtask

   // Waits for the next handshake and takes the values from before the edge
   task automatic receive_flit(output dii_word d, output logic l);
      @(posedge clk);
      while (!(debug_out_valid && debug_out_ready)) begin
         @(posedge clk);
      end
      d = debug_out_data;
      l = debug_out_last;
   endtask

   task automatic drain_expected();
      dii_word d;
      logic l;
      int k;
      k = 0;
      while (exp_data.size() > 0) begin
         receive_flit(d, l);
         check_word($sformatf("debug_out_data flit %0d", k), d, exp_data.pop_front());
         check_last($sformatf("debug_out_last flit %0d", k), l, exp_last.pop_front());
         k++;
      end
   endtask

   task automatic check_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_last("debug_out_valid", debug_out_valid, 1'b0);
      end
   endtask

   task automatic test_single_event();
      logic [DATA_WIDTH-1:0] ev;
      // Top byte all ones so the zero padding of word 4 shows
      ev = 72'hff_fedc_ba98_7654_3210;
      ready_mode = READY_HIGH;
      queue_event(ev);
      send_event(ev);
      // First flit valid only after the second edge following the strobe
      check_last("debug_out_valid", debug_out_valid, 1'b0);
      @(negedge clk);
      check_last("debug_out_valid", debug_out_valid, 1'b1);
      drain_expected();
      check_idle(5);
   endtask

   task automatic test_back_pressure();
      logic [95:0] rnd;
      int i;
      for (i = 0; i < BP_EVENTS; i++) begin
         rnd = {$random(seed), $random(seed), $random(seed)};
         ready_mode = READY_RANDOM;
         queue_event(rnd[DATA_WIDTH-1:0]);
         send_event(rnd[DATA_WIDTH-1:0]);
         drain_expected();
      end
      ready_mode = READY_HIGH;
      check_idle(4);
   endtask

   task automatic test_overflow();
      logic [DATA_WIDTH-1:0] ev;
      int i;
      ev = 72'h5a_1111_2222_3333_4444;
      ready_mode = READY_LOW;
      repeat (2) @(negedge clk);
      queue_event(ev);
      queue_overflow(16'd3);
      send_event(ev);
      // Three more while the first one is stuck
      for (i = 1; i <= 3; i++) begin
         send_event(DATA_WIDTH'(i));
      end
      // Stalled flit holds DEST
      check_last("debug_out_valid", debug_out_valid, 1'b1);
      check_word("debug_out_data under stall", debug_out_data, dest);
      ready_mode = READY_HIGH;
      drain_expected();
      check_idle(5);
   endtask

   task automatic test_recovery();
      logic [95:0] rnd;
      rnd = {$random(seed), $random(seed), $random(seed)};
      ready_mode = READY_HIGH;
      queue_event(rnd[DATA_WIDTH-1:0]);
      send_event(rnd[DATA_WIDTH-1:0]);
      drain_expected();
      // No second overflow report may follow
      check_idle(20);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all tests finished");
      abort_run();
   end

   initial begin
      seed = 32'h69bf_e2de;
      clk = 1'b0;
      rst = 1'b1;
      id = 16'h0a5c;
      dest = 16'h0013;
      trace_valid = 1'b0;
      trace_data = '0;
      debug_out_ready = 1'b0;
      ready_mode = READY_HIGH;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_idle(10);
      test_single_event();
      test_back_pressure();
      test_overflow();
      test_recovery();
      $display("test passed");
      $finish;
   end

endmodule

/* osd_event_trace.f */
verilog/osd_trace_pkg.sv
verilog/osd_event_capture.sv
verilog/osd_event_packetization.sv
verilog/osd_event_packetization_fixedwidth.sv
verilog/osd_event_trace_top.sv
verification/osd_event_trace_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the trace port testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
   --top-module osd_event_trace_tb -f osd_event_trace.f -o osd_event_trace_sim &&
   ./obj_dir/osd_event_trace_sim > sim.log 2>&1
cat sim.log 2>/dev/null
# The log decides, a missing log counts as failure
grep -qx "test passed" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }
